// File: source/y_update_pkg.sv
/*
 * Shared sizing constants and packed types for the Y matrix update
 * controller. Every RTL file refers to these by scoped name.
 */
`default_nettype none

package y_update_pkg;

   localparam int INDEX_W        = 16;
   localparam int PART_W         = 24;
   localparam int SLOTS_PER_LINE = 8;  // two memory words of four slots

   localparam logic [INDEX_W-1:0] EMPTY_TAG = '1;  // unused slot marker

   typedef struct packed {
      logic [PART_W-1:0] re;
      logic [PART_W-1:0] im;
   } y_value_t;

   typedef struct packed {
      logic [INDEX_W-1:0] tag;  // column index of the entry
      y_value_t           value;
   } y_slot_t;

   // slot 0 sits in the low bits of the line
   typedef y_slot_t [SLOTS_PER_LINE-1:0] row_line_t;

   typedef struct packed {
      logic [INDEX_W-1:0] row;
      logic [INDEX_W-1:0] col;
      y_value_t           delta;
   } change_t;

   typedef enum logic {
      op_diag,
      op_offdiag
   } op_kind_t;

   typedef struct packed {
      op_kind_t kind;
      y_value_t value;  // current matrix entry
      y_value_t delta;
   } exec_op_t;

   typedef enum logic [1:0] {
      status_ok,
      status_missing,
      status_timeout
   } status_t;

endpackage

`default_nettype wire

// File: source/fetch_timer.sv
/*
 * Fetch response watchdog. start arms a down-counter, clear disarms it,
 * and expired is high for one cycle TIMEOUT_CYCLES cycles after start.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_timer
#(
   parameter int TIMEOUT_CYCLES = 16
)
(
   input  logic clock,
   input  logic reset,
   input  logic start,
   input  logic clear,
   output logic expired
);

   localparam int COUNT_W = $clog2(TIMEOUT_CYCLES + 1);

   logic               armed;
   logic [COUNT_W-1:0] count;

   assign expired = armed && (count == '0);

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         armed <= 1'b0;
         count <= '0;
      end
      else if (start)
      begin
         armed <= 1'b1;
         count <= COUNT_W'(TIMEOUT_CYCLES - 1);  // reaches zero on the expiry cycle
      end
      else if (clear || expired)
         armed <= 1'b0;  // one pulse only
      else if (armed)
         count <= count - 1'b1;
   end

endmodule

`default_nettype wire

// File: source/row_search.sv
/*
 * Tag search over one fetched row line. Both keys are resolved in the
 * same cycle; the lowest matching slot wins for each key. Results are
 * registered and marked by search_valid one cycle after row_valid.
 */
`timescale 1ns/1ps
`default_nettype none

module row_search
(
   input  logic                                clock,
   input  logic                                reset,
   input  logic                                row_valid,
   input  y_update_pkg::row_line_t             row_data,
   input  logic [y_update_pkg::INDEX_W-1:0]    diag_key,
   input  logic [y_update_pkg::INDEX_W-1:0]    off_key,
   output logic                                search_valid,
   output logic                                diag_hit,
   output logic                                off_hit,
   output y_update_pkg::y_value_t              diag_value,
   output y_update_pkg::y_value_t              off_value
);

   typedef struct packed {
      logic                   hit;
      y_update_pkg::y_value_t value;
   } match_t;

   match_t diag_match;
   match_t off_match;

   // walk from the top slot down so the lowest match is kept
   function automatic match_t find_tag(input y_update_pkg::row_line_t line,
                                       input logic [y_update_pkg::INDEX_W-1:0] key);
      match_t result;
      result = '0;
      for (int i = y_update_pkg::SLOTS_PER_LINE - 1; i >= 0; i--)
      begin
         if (line[i].tag != y_update_pkg::EMPTY_TAG && line[i].tag == key)
         begin
            result.hit   = 1'b1;
            result.value = line[i].value;
         end
      end
      return result;
   endfunction

   assign diag_match = find_tag(row_data, diag_key);
   assign off_match  = find_tag(row_data, off_key);

   always_ff @(posedge clock)
   begin
      if (!reset)
         search_valid <= 1'b0;
      else
         search_valid <= row_valid;
   end

   // results hold until the next line arrives
   always_ff @(posedge clock)
   begin
      if (row_valid)
      begin
         diag_hit   <= diag_match.hit;
         off_hit    <= off_match.hit;
         diag_value <= diag_match.value;
         off_value  <= off_match.value;
      end
   end

endmodule

`default_nettype wire

// File: source/y_update_fsm.sv
/*
 * Sequencer for one Y matrix change. Pass one fetches the request row and
 * issues the diagonal then the off-diagonal operation; pass two does the
 * same on the column row with the keys swapped. All outputs are registered.
 */
`timescale 1ns/1ps
`default_nettype none

module y_update_fsm
(
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             req_valid,
   input  y_update_pkg::change_t            req,
   output logic                             busy,
   output logic                             fetch_valid,
   output logic [y_update_pkg::INDEX_W-1:0] fetch_row,
   output logic [y_update_pkg::INDEX_W-1:0] diag_key,
   output logic [y_update_pkg::INDEX_W-1:0] off_key,
   output logic                             timer_start,
   output logic                             timer_clear,
   input  logic                             expired,
   input  logic                             row_valid,
   input  logic                             search_valid,
   input  logic                             diag_hit,
   input  logic                             off_hit,
   input  y_update_pkg::y_value_t           diag_value,
   input  y_update_pkg::y_value_t           off_value,
   output logic                             exec_valid,
   output y_update_pkg::exec_op_t           exec_op,
   input  logic                             exec_done,
   output logic                             done_valid,
   output y_update_pkg::status_t            done_status
);

   typedef enum logic [2:0] {
      st_idle,
      st_fetch_wait,
      st_search_wait,
      st_diag_op,
      st_off_op,
      st_finish
   } state_t;

   state_t                           state;
   state_t                           state_next;
   logic                             pass;       // 0 = row pass, 1 = col pass
   logic                             pass_next;
   logic                             accept;
   logic                             issue_fetch;
   logic                             issue_diag;
   logic                             issue_off;
   logic                             finish_req;
   y_update_pkg::status_t            finish_status;
   logic [y_update_pkg::INDEX_W-1:0] key_a;      // row to fetch, also the diagonal tag
   logic [y_update_pkg::INDEX_W-1:0] key_b;
   y_update_pkg::change_t            req_q;
   y_update_pkg::y_value_t           off_hold;   // off-diagonal value waits for first done

   assign accept = (state == st_idle) && req_valid;

   always_comb
   begin
      state_next    = state;
      pass_next     = pass;
      issue_fetch   = 1'b0;
      issue_diag    = 1'b0;
      issue_off     = 1'b0;
      finish_req    = 1'b0;
      finish_status = y_update_pkg::status_ok;
      key_a         = req.row;
      key_b         = req.col;
      case (state)
         st_idle:
         begin
            if (req_valid)
            begin
               issue_fetch = 1'b1;
               pass_next   = 1'b0;
               state_next  = st_fetch_wait;
            end
         end
         st_fetch_wait:
         begin
            if (row_valid)  // a late line beats the timeout
               state_next = st_search_wait;
            else if (expired)
            begin
               finish_req    = 1'b1;
               finish_status = y_update_pkg::status_timeout;
               state_next    = st_finish;
            end
         end
         st_search_wait:
         begin
            if (search_valid)
            begin
               if (diag_hit && off_hit)
               begin
                  issue_diag = 1'b1;
                  state_next = st_diag_op;
               end
               else
               begin
                  finish_req    = 1'b1;
                  finish_status = y_update_pkg::status_missing;
                  state_next    = st_finish;
               end
            end
         end
         st_diag_op:
         begin
            if (exec_done)
            begin
               issue_off  = 1'b1;
               state_next = st_off_op;
            end
         end
         st_off_op:
         begin
            if (exec_done && !pass)
            begin
               issue_fetch = 1'b1;  // second pass on the column row
               pass_next   = 1'b1;
               key_a       = req_q.col;
               key_b       = req_q.row;
               state_next  = st_fetch_wait;
            end
            else if (exec_done)
            begin
               finish_req = 1'b1;
               state_next = st_finish;
            end
         end
         st_finish:
            state_next = st_idle;
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state       <= st_idle;
         pass        <= 1'b0;
         busy        <= 1'b0;
         fetch_valid <= 1'b0;
         timer_start <= 1'b0;
         timer_clear <= 1'b0;
         exec_valid  <= 1'b0;
         done_valid  <= 1'b0;
      end
      else
      begin
         state       <= state_next;
         pass        <= pass_next;
         busy        <= (state_next != st_idle);  // drops the cycle after done
         fetch_valid <= issue_fetch;
         timer_start <= issue_fetch;
         timer_clear <= (state == st_fetch_wait) && row_valid;
         exec_valid  <= issue_diag || issue_off;
         done_valid  <= finish_req;
      end
   end

   always_ff @(posedge clock)
   begin
      if (accept)
         req_q <= req;
      if (issue_fetch)
      begin
         fetch_row <= key_a;
         diag_key  <= key_a;
         off_key   <= key_b;
      end
      if (issue_diag)
      begin
         exec_op  <= '{kind: y_update_pkg::op_diag, value: diag_value, delta: req_q.delta};
         off_hold <= off_value;
      end
      if (issue_off)
         exec_op <= '{kind: y_update_pkg::op_offdiag, value: off_hold, delta: req_q.delta};
      if (finish_req)
         done_status <= finish_status;
   end

endmodule

`default_nettype wire

// File: source/y_update_top.sv
/*
 * Y matrix update controller. Takes change requests, fetches rows from an
 * external row memory and issues operations to an external execution
 * unit. All interfaces are single-cycle strobes without back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module y_update_top
#(
   parameter int TIMEOUT_CYCLES = 16  // fetch response budget
)
(
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             req_valid,
   input  y_update_pkg::change_t            req,
   output logic                             busy,
   output logic                             fetch_valid,
   output logic [y_update_pkg::INDEX_W-1:0] fetch_row,
   input  logic                             row_valid,
   input  y_update_pkg::row_line_t          row_data,
   output logic                             exec_valid,
   output y_update_pkg::exec_op_t           exec_op,
   input  logic                             exec_done,
   output logic                             done_valid,
   output y_update_pkg::status_t            done_status
);

   logic [y_update_pkg::INDEX_W-1:0] diag_key;
   logic [y_update_pkg::INDEX_W-1:0] off_key;
   logic                             timer_start;
   logic                             timer_clear;
   logic                             expired;
   logic                             search_valid;
   logic                             diag_hit;
   logic                             off_hit;
   y_update_pkg::y_value_t           diag_value;
   y_update_pkg::y_value_t           off_value;

   y_update_fsm fsm_inst (
      .clock        (clock),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .busy         (busy),
      .fetch_valid  (fetch_valid),
      .fetch_row    (fetch_row),
      .diag_key     (diag_key),
      .off_key      (off_key),
      .timer_start  (timer_start),
      .timer_clear  (timer_clear),
      .expired      (expired),
      .row_valid    (row_valid),
      .search_valid (search_valid),
      .diag_hit     (diag_hit),
      .off_hit      (off_hit),
      .diag_value   (diag_value),
      .off_value    (off_value),
      .exec_valid   (exec_valid),
      .exec_op      (exec_op),
      .exec_done    (exec_done),
      .done_valid   (done_valid),
      .done_status  (done_status)
   );

   fetch_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) timer_inst (
      .clock   (clock),
      .reset   (reset),
      .start   (timer_start),
      .clear   (timer_clear),
      .expired (expired)
   );

   row_search search_inst (
      .clock        (clock),
      .reset        (reset),
      .row_valid    (row_valid),
      .row_data     (row_data),
      .diag_key     (diag_key),
      .off_key      (off_key),
      .search_valid (search_valid),
      .diag_hit     (diag_hit),
      .off_hit      (off_hit),
      .diag_value   (diag_value),
      .off_value    (off_value)
   );

endmodule

`default_nettype wire

// File: tb/y_update_tb.sv
/*
 * Self-checking testbench for the Y matrix update controller. Loads a row
 * memory image and change requests from the test data file, models the
 * row memory and the execution unit, and checks every fetch, operation
 * and completion against its own tag search over the image.
 */
`timescale 1ns/1ps
`default_nettype none

module y_update_tb;

   localparam int CLK_PERIOD = 20;
   localparam int MAX_ROWS   = 16;
   localparam int MAX_REQS   = 32;

   logic                             clock;
   logic                             reset;
   logic                             req_valid;
   y_update_pkg::change_t            req;
   logic                             busy;
   logic                             fetch_valid;
   logic [y_update_pkg::INDEX_W-1:0] fetch_row;
   logic                             row_valid;
   y_update_pkg::row_line_t          row_data;
   logic                             exec_valid;
   y_update_pkg::exec_op_t           exec_op;
   logic                             exec_done;
   logic                             done_valid;
   y_update_pkg::status_t            done_status;

   logic [y_update_pkg::INDEX_W-1:0] img_row [MAX_ROWS];
   y_update_pkg::row_line_t          img_line [MAX_ROWS];
   y_update_pkg::change_t            req_list [MAX_REQS];
   int                               req_status [MAX_REQS];
   logic [y_update_pkg::INDEX_W-1:0] exp_fetch [$];
   y_update_pkg::exec_op_t           exp_ops [$];
   y_update_pkg::status_t            exp_status;
   integer                           seed;
   int                               img_count;
   int                               req_count;
   int                               mismatch_count;
   int                               protocol_count;
   int                               done_total;
   logic                             loaded;
   logic                             in_request;    // accepted and not yet completed
   logic                             exec_pending;

   y_update_top y_update_inst (
      .clock       (clock),
      .reset       (reset),
      .req_valid   (req_valid),
      .req         (req),
      .busy        (busy),
      .fetch_valid (fetch_valid),
      .fetch_row   (fetch_row),
      .row_valid   (row_valid),
      .row_data    (row_data),
      .exec_valid  (exec_valid),
      .exec_op     (exec_op),
      .exec_done   (exec_done),
      .done_valid  (done_valid),
      .done_status (done_status)
   );

   always #(CLK_PERIOD / 2) clock = ~clock;

   task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         mismatch_count++;
         $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic report_protocol(input string msg);
      protocol_count++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic load_testdata();
      integer                           fd;
      string                            kind;
      string                            rest;
      logic [y_update_pkg::INDEX_W-1:0] f_row;
      logic [y_update_pkg::INDEX_W-1:0] f_col;
      logic [47:0]                      f_val;
      integer                           f_status;
      fd = $fopen("tb/y_update_testdata.txt", "r");
      if (fd == 0)
      begin
         report_protocol("could not open the test data file");
         return;
      end
      while ($fscanf(fd, "%s", kind) == 1)
      begin
         if (kind == "M")
         begin
            void'($fscanf(fd, "%h", f_row));
            img_row[img_count] = f_row;
            for (int i = 0; i < y_update_pkg::SLOTS_PER_LINE; i++)
            begin
               void'($fscanf(fd, "%h %h", f_col, f_val));
               img_line[img_count][i].tag   = f_col;
               img_line[img_count][i].value = f_val;
            end
            img_count++;
         end
         else if (kind == "R")
         begin
            void'($fscanf(fd, "%h %h %h %d", f_row, f_col, f_val, f_status));
            req_list[req_count].row   = f_row;
            req_list[req_count].col   = f_col;
            req_list[req_count].delta = f_val;
            req_status[req_count]     = f_status;
            req_count++;
         end
         else
            void'($fgets(rest, fd));  // comment line
      end
      $fclose(fd);
   endtask

   function automatic int find_row(input logic [y_update_pkg::INDEX_W-1:0] key);
      int idx;
      idx = -1;
      for (int i = 0; i < img_count; i++)
         if (idx < 0 && img_row[i] == key)
            idx = i;
      return idx;
   endfunction

   // hit flag on top of the value; first slot from slot 0 upward wins
   function automatic logic [48:0] lookup_tag(input y_update_pkg::row_line_t line,
                                              input logic [y_update_pkg::INDEX_W-1:0] key);
      logic [48:0] found;
      found = '0;
      for (int i = 0; i < y_update_pkg::SLOTS_PER_LINE; i++)
         if (!found[48] && line[i].tag != 16'hffff && line[i].tag == key)
            found = {1'b1, line[i].value};
      return found;
   endfunction

   task automatic build_expected(input int k);
      logic [y_update_pkg::INDEX_W-1:0] keys [2];
      logic [48:0]                      diag;
      logic [48:0]                      off;
      y_update_pkg::exec_op_t           op;
      int                               idx;
      logic                             stop;
      stop       = 1'b0;
      exp_status = y_update_pkg::status_ok;
      keys[0]    = req_list[k].row;
      keys[1]    = req_list[k].col;
      for (int p = 0; p < 2; p++)
      begin
         if (!stop)
         begin
            exp_fetch.push_back(keys[p]);
            idx = find_row(keys[p]);
            if (idx < 0)
            begin
               exp_status = y_update_pkg::status_timeout;  // memory never answers
               stop       = 1'b1;
            end
            else
            begin
               diag = lookup_tag(img_line[idx], keys[p]);
               off  = lookup_tag(img_line[idx], keys[1-p]);
               if (!diag[48] || !off[48])
               begin
                  exp_status = y_update_pkg::status_missing;
                  stop       = 1'b1;
               end
               else
               begin
                  op.kind  = y_update_pkg::op_diag;
                  op.value = diag[47:0];
                  op.delta = req_list[k].delta;
                  exp_ops.push_back(op);
                  op.kind  = y_update_pkg::op_offdiag;
                  op.value = off[47:0];
                  exp_ops.push_back(op);
               end
            end
         end
      end
      check_value(exp_status, req_status[k], "status in test data");
   endtask

   task automatic send_request(input y_update_pkg::change_t change);
      @(posedge clock);
      #2;
      req_valid = 1'b1;
      req       = change;
      @(posedge clock);
      #2;
      req_valid = 1'b0;
   endtask

   // row memory answers after 1 to 4 cycles and stays silent for rows not in the image
   always @(negedge clock)
   begin : memory_model
      int latency;
      int idx;
      if (reset && fetch_valid)
      begin
         latency = 1 + ($unsigned($random(seed)) % 4);
         idx     = find_row(fetch_row);
         if (idx >= 0)
         begin
            repeat (latency) @(posedge clock);
            #2;
            row_valid = 1'b1;
            row_data  = img_line[idx];
            @(posedge clock);
            #2;
            row_valid = 1'b0;
         end
      end
   end

   // execution unit pulses done 1 to 5 cycles after each operation
   always @(negedge clock)
   begin : exec_model
      int latency;
      if (reset && exec_valid)
      begin
         latency = 1 + ($unsigned($random(seed)) % 5);
         repeat (latency) @(posedge clock);
         #2;
         exec_done = 1'b1;
         @(posedge clock);
         #2;
         exec_done = 1'b0;
      end
   end

   always @(negedge clock)
   begin : monitor
      logic [y_update_pkg::INDEX_W-1:0] want_row;
      y_update_pkg::exec_op_t           want_op;
      if (reset)
      begin
         check_value(busy, in_request, "busy");
         if (fetch_valid)
         begin
            if (!in_request || exp_fetch.size() == 0)
               report_protocol("a row fetch was issued when none was expected");
            else
            begin
               want_row = exp_fetch.pop_front();
               check_value(fetch_row, want_row, "fetch_row");
            end
         end
         if (exec_valid)
         begin
            if (exec_pending)
               report_protocol("a second operation was issued before exec_done");
            exec_pending = 1'b1;
            if (exp_ops.size() == 0)
               report_protocol("an operation was issued when none was expected");
            else
            begin
               want_op = exp_ops.pop_front();
               check_value(exec_op, want_op, "exec_op");
            end
         end
         if (exec_done)
            exec_pending = 1'b0;
         if (done_valid)
         begin
            if (!in_request)
               report_protocol("done_valid came with no request in progress");
            check_value(done_status, exp_status, "done_status");
            if (exp_fetch.size() != 0 || exp_ops.size() != 0)
               report_protocol("request completed before all expected fetches and operations");
            done_total++;
            in_request = 1'b0;
         end
         if (req_valid && !busy && !in_request)
            in_request = 1'b1;  // accepted this cycle
      end
   end

   initial
   begin
      y_update_pkg::change_t spurious;
      seed           = 80117;
      clock          = 1'b0;
      reset          = 1'b0;
      req_valid      = 1'b0;
      req            = '0;
      row_valid      = 1'b0;
      row_data       = '0;
      exec_done      = 1'b0;
      exp_status     = y_update_pkg::status_ok;
      img_count      = 0;
      req_count      = 0;
      mismatch_count = 0;
      protocol_count = 0;
      done_total     = 0;
      in_request     = 1'b0;
      exec_pending   = 1'b0;
      loaded         = 1'b0;
      load_testdata();
      loaded = 1'b1;
      repeat (4) @(posedge clock);
      #2;
      reset = 1'b1;
      for (int k = 0; k < req_count; k++)
      begin
         build_expected(k);
         send_request(req_list[k]);
         spurious       = req_list[k];
         spurious.row   = img_row[0];
         spurious.delta = ~req_list[k].delta;
         send_request(spurious);  // arrives while busy, must be dropped
         while (done_total < k + 1)
            @(posedge clock);
         @(posedge clock);
      end
      repeat (10) @(posedge clock);
      $display("errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
      if (mismatch_count == 0 && protocol_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial
   begin
      wait (loaded);
      repeat (req_count * 200 + 40) @(posedge clock);
      report_protocol("watchdog expired, a request never completed");
      $display("errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/y_update_testdata.txt
# M <row> then eight slots of <tag> <value>, slot 0 first; value is re:im, 24 bits each, hex
# R <row> <col> <delta re:im> <expected status: 0 ok, 1 missing, 2 timeout>
M 0001 0001 11000011 ffff 0 0005 15000015 ffff 0 ffff 0 0002 12000012 ffff 0 ffff 0
M 0002 0006 26000026 0001 21000021 ffff 0 ffff 0 ffff 0 ffff 0 ffff 0 0002 22000022
M 0003 0003 33000033 ffff 0 ffff 0 0007 37000037 ffff 0 ffff 0 ffff 0 ffff 0
M 0004 0004 44000044 0003 43000043 ffff 0 ffff 0 ffff 0 ffff 0 ffff 0 ffff 0
M 0005 0005 55000055 ffff 0 ffff 0 ffff 0 0002 52000052 ffff 0 ffff 0 ffff 0
M 0006 ffff 0 0002 62000062 ffff 0 0006 66000066 0002 6f00006f ffff 0 0006 6e00006e ffff 0
R 0001 0002 1000002 0
R 0003 0004 3000004 1
R 0001 0005 5000001 1
R 0009 0001 9000001 2
R 0006 0002 6000002 0
R 0003 ffff 3ffff 1
R 0004 0003 4000003 1
R 0003 0007 3000007 2
R 0002 0001 2000001 0

// File: files.f
source/y_update_pkg.sv
source/fetch_timer.sv
source/row_search.sv
source/y_update_fsm.sv
source/y_update_top.sv
tb/y_update_tb.sv

// File: Bender.yml
package:
  name: y_update

sources:
  - source/y_update_pkg.sv
  - source/fetch_timer.sv
  - source/row_search.sv
  - source/y_update_fsm.sv
  - source/y_update_top.sv
  - target: simulation
    files:
      - tb/y_update_tb.sv
